// File: verilog/patch_front_end_defines.svh
`ifndef PATCH_FRONT_END_DEFINES_SVH
`define PATCH_FRONT_END_DEFINES_SVH

// link and DRAM widths
`define XB_WIDTH         32
`define APP_DATA_WIDTH   64
`define ADDR_WIDTH       27

// coefficient storage, one BL8 burst per four messages
`define ADDR_INC         8
`define START_ADDR       0
`define WORDS_PER_BURST  4

// pixel position and value
`define FP_SIZE          20
`define COL_BITS         11
`define ROW_BITS         12
`define FRAME_BITS       20

`define FIFO_AW          4

// message tags in bits 1:0
`define DS_TAG           2'b00
`define COEFF_END_TAG    2'b01

// patch row sits in bits 7:4 of a coefficient word
`define COEFF_ROW_LSB    4

`endif

// File: verilog/xb_msg_pkg.sv
`default_nettype none

`include "patch_front_end_defines.svh"

package xb_msg_pkg;

  // pixel message layout, lsb first: tag, lval, fval, reserved, pixel
  typedef struct packed {
    logic [`FP_SIZE-1:0] pix;
    logic [7:0]          rsvd;
    logic                fval;
    logic                lval;
    logic [1:0]          tag;
  } xb_pix_view_t;

  // the router decides which view applies to a given word
  typedef union packed {
    logic [`XB_WIDTH-1:0] raw;
    xb_pix_view_t         pix;
  } xb_msg_u;

  // two pixels per beat, pix1 came first on the link
  typedef struct packed {
    logic                   valid;
    logic                   fval;
    logic                   lval;
    logic [`ROW_BITS-1:0]   row;
    logic [`COL_BITS-1:0]   col;
    logic [`FRAME_BITS-1:0] frame;
    logic [`FP_SIZE-1:0]    pix0;
    logic [`FP_SIZE-1:0]    pix1;
  } pixel_beat_t;

  typedef enum logic [1:0] {
    STANDBY,
    INTRALINE,
    INTERLINE,
    INTERFRAME
  } pix_state_e;

endpackage

`default_nettype wire

// File: verilog/dram_pkg.sv
`default_nettype none

`include "patch_front_end_defines.svh"

package dram_pkg;

  typedef enum logic [2:0] {
    ERROR,
    MSG_WAIT,
    WR_WAIT,
    WR1,
    WR2,
    READING,
    THROTTLED,
    INTERFRAME
  } dram_state_e;

  // command side of the memory controller app port
  typedef struct packed {
    logic                   en;
    logic                   read;
    logic [`ADDR_WIDTH-1:0] addr;
  } app_req_t;

  // one coefficient word returned from DRAM, tagged with its patch row
  typedef struct packed {
    logic                       valid;
    logic [3:0]                 row;
    logic [`APP_DATA_WIDTH-1:0] data;
  } coeff_rec_t;

endpackage

`default_nettype wire

// File: verilog/msg_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "patch_front_end_defines.svh"

module msg_fifo #(
  parameter int WIDTH = `XB_WIDTH
) (
  input  wire              CLK,
  input  wire              fds_val,
  input  wire              wren,
  input  wire [WIDTH-1:0]  din,
  input  wire              rden,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  localparam int DEPTH = 2 ** `FIFO_AW;

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`FIFO_AW:0]   count;
  logic                wr_ok;
  logic                rd_ok;

  assign full  = count == DEPTH;
  assign empty = count == '0;
  // show-ahead, head word is always presented
  assign dout  = mem[rd_ptr];

  assign wr_ok = wren && !full;
  assign rd_ok = rden && !empty;

  always_ff @(posedge CLK) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      count <= count + wr_ok - rd_ok;
    end
  end

  // producer and consumer must honour full and empty
  a_no_overflow_underflow: assert property (
    @(posedge CLK) disable iff (fds_val) !(wren && full) && !(rden && empty));

endmodule

`default_nettype wire

// File: verilog/msg_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "patch_front_end_defines.svh"

module msg_router (
  input  wire                      CLK,
  input  wire                      fds_val,
  input  wire                      pc_msg_pending,
  input  wire xb_msg_pkg::xb_msg_u pc_msg,
  output logic                     pc_msg_ack,
  input  wire                      pix_rden,
  output xb_msg_pkg::xb_msg_u      pix_msg,
  output logic                     pix_empty,
  input  wire                      dram_rden,
  output xb_msg_pkg::xb_msg_u      dram_msg,
  output logic                     dram_empty
);

  import xb_msg_pkg::*;

  // pixel queue keeps only pixel value and the two flags
  localparam int PIX_W = `FP_SIZE + 2;

  logic [$clog2(`WORDS_PER_BURST)-1:0] word_cnt;
  logic                                is_pix;
  xb_msg_u                             msg_q;
  logic                                pix_wren;
  logic                                dram_wren;
  logic                                pix_full;
  logic                                dram_full;
  logic [PIX_W-1:0]                    pix_dout;

  assign pc_msg_ack = pc_msg_pending && !pix_full && !dram_full;

  // a DS tag counts only on a burst boundary
  assign is_pix = pc_msg.pix.tag == `DS_TAG && word_cnt == '0;

  always_ff @(posedge CLK) begin
    if (pc_msg_ack) msg_q <= pc_msg;
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      word_cnt  <= '0;
      pix_wren  <= 1'b0;
      dram_wren <= 1'b0;
    end else begin
      pix_wren  <= pc_msg_ack && is_pix;
      dram_wren <= pc_msg_ack && !is_pix;
      if (pc_msg_ack && !is_pix) begin
        if (word_cnt == $clog2(`WORDS_PER_BURST)'(`WORDS_PER_BURST - 1)) word_cnt <= '0;
        else word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  msg_fifo #(.WIDTH(PIX_W)) pix_fifo (
    .CLK   (CLK),
    .fds_val(fds_val),
    .wren  (pix_wren),
    .din   ({msg_q.pix.pix, msg_q.pix.fval, msg_q.pix.lval}),
    .rden  (pix_rden),
    .dout  (pix_dout),
    .full  (pix_full),
    .empty (pix_empty)
  );

  msg_fifo #(.WIDTH(`XB_WIDTH)) dram_fifo (
    .CLK   (CLK),
    .fds_val(fds_val),
    .wren  (dram_wren),
    .din   (msg_q.raw),
    .rden  (dram_rden),
    .dout  (dram_msg.raw),
    .full  (dram_full),
    .empty (dram_empty)
  );

  // rebuild the pixel view from the narrow queue word
  always_comb begin
    pix_msg          = '0;
    pix_msg.pix.pix  = pix_dout[PIX_W-1:2];
    pix_msg.pix.fval = pix_dout[1];
    pix_msg.pix.lval = pix_dout[0];
    pix_msg.pix.tag  = `DS_TAG;
  end

endmodule

`default_nettype wire

// File: verilog/pixel_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "patch_front_end_defines.svh"

module pixel_tracker (
  input  wire                      CLK,
  input  wire                      fds_val,
  input  wire xb_msg_pkg::xb_msg_u pix_msg,
  input  wire                      pix_empty,
  output logic                     pix_rden,
  output xb_msg_pkg::pixel_beat_t  beat,
  output logic                     frame_gap
);

  import xb_msg_pkg::*;

  pix_state_e             state;
  logic                   second;
  logic                   pair_done;
  logic                   first_fval;
  logic                   first_lval;
  logic [`FP_SIZE-1:0]    first_pix;
  logic [`ROW_BITS-1:0]   row;
  logic [`COL_BITS-1:0]   col;
  logic [`FRAME_BITS-1:0] frame;

  // the pixel stream never stalls
  assign pix_rden  = !pix_empty;
  assign frame_gap = !pix_msg.pix.fval;
  assign pair_done = pix_rden && second;

  // first half of a pair
  always_ff @(posedge CLK) begin
    if (pix_rden && !second) begin
      first_fval <= pix_msg.pix.fval;
      first_lval <= pix_msg.pix.lval;
      first_pix  <= pix_msg.pix.pix;
    end
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      second <= 1'b0;
      beat   <= '0;
      state  <= STANDBY;
      row    <= '0;
      col    <= '0;
      frame  <= '0;
    end else begin
      beat.valid <= 1'b0;
      if (pix_rden) second <= !second;
      if (pair_done) begin
        // beat reports the position before this update
        beat <= '{valid: 1'b1, fval: first_fval, lval: first_lval,
                  row: row, col: col, frame: frame,
                  pix0: pix_msg.pix.pix, pix1: first_pix};
        case (state)
          STANDBY: begin
            if (!first_fval) begin
              row   <= '0;
              col   <= '0;
              frame <= '0;
              state <= INTERFRAME;
            end
          end
          INTERFRAME: begin
            if (first_lval) begin
              row   <= '0;
              col   <= '0;
              state <= INTRALINE;
            end
          end
          INTRALINE: begin
            if (first_lval) begin
              col <= col + `COL_BITS'(2);
            end else if (first_fval) begin
              row   <= row + 1'b1;
              state <= INTERLINE;
            end else begin
              frame <= frame + 1'b1;
              state <= INTERFRAME;
            end
          end
          INTERLINE: begin
            if (first_lval) begin
              col   <= '0;
              state <= INTRALINE;
            end
          end
          default: state <= STANDBY;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dram_coeff_ifc.sv
`timescale 1ns/1ps
`default_nettype none

`include "patch_front_end_defines.svh"

module dram_coeff_ifc (
  input  wire                             CLK,
  input  wire                             fds_val,
  input  wire xb_msg_pkg::xb_msg_u        dram_msg,
  input  wire                             dram_empty,
  output logic                            dram_rden,
  input  wire                             frame_gap,
  input  wire                             pix_empty,
  input  wire                             app_rdy,
  output dram_pkg::app_req_t              app_req,
  input  wire                             app_wdf_rdy,
  output logic                            app_wdf_wren,
  output logic                            app_wdf_end,
  output logic [`APP_DATA_WIDTH-1:0]      app_wdf_data,
  input  wire                             app_rd_data_valid,
  input  wire [`APP_DATA_WIDTH-1:0]       app_rd_data,
  input  wire                             coeff_high,
  output dram_pkg::coeff_rec_t            coeff_out,
  output logic                            error
);

  import dram_pkg::*;

  localparam int IDX_W = $clog2(`WORDS_PER_BURST);

  dram_state_e                  state;
  logic [2*`APP_DATA_WIDTH-1:0] wr_buf;
  logic [IDX_W-1:0]             wr_idx;
  logic [`ADDR_WIDTH-1:0]       end_addr;
  logic                         beat1_go;
  logic                         beat2_go;

  assign dram_rden = state == MSG_WAIT && !dram_empty;
  assign beat1_go  = state == WR_WAIT && app_rdy && app_wdf_rdy;
  assign beat2_go  = state == WR1 && app_wdf_rdy;
  assign error     = state == ERROR;

  // burst assembly and write data, lowest word first
  always_ff @(posedge CLK) begin
    if (dram_rden) wr_buf[wr_idx*`XB_WIDTH +: `XB_WIDTH] <= dram_msg.raw;
    if (beat1_go) app_wdf_data <= wr_buf[0 +: `APP_DATA_WIDTH];
    else if (beat2_go) app_wdf_data <= wr_buf[`APP_DATA_WIDTH +: `APP_DATA_WIDTH];
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state        <= MSG_WAIT;
      wr_idx       <= '0;
      end_addr     <= `ADDR_WIDTH'(`START_ADDR);
      app_req.en   <= 1'b0;
      app_req.read <= 1'b0;
      app_req.addr <= `ADDR_WIDTH'(`START_ADDR);
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b1;
    end else begin
      case (state)
        MSG_WAIT: begin
          if (dram_rden) begin
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == IDX_W'(`WORDS_PER_BURST - 1)) begin
              app_req.en <= 1'b1;
              state      <= WR_WAIT;
            end
          end
        end
        WR_WAIT: begin
          if (beat1_go) begin
            // command accepted, point at the next burst
            app_req.addr <= app_req.addr + `ADDR_WIDTH'(`ADDR_INC);
            app_req.en   <= 1'b0;
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            state        <= WR1;
          end
        end
        WR1: begin
          if (beat2_go) begin
            app_wdf_end <= 1'b1;
            state       <= WR2;
          end
        end
        WR2: begin
          app_wdf_wren <= 1'b0;
          if (!app_wdf_rdy) begin
            state <= ERROR;
          end else if (app_wdf_data[1:0] == `COEFF_END_TAG) begin
            // word 2 marks the end of the coefficients
            end_addr     <= app_req.addr - `ADDR_WIDTH'(`ADDR_INC);
            app_req.addr <= `ADDR_WIDTH'(`START_ADDR);
            app_req.read <= 1'b1;
            app_req.en   <= 1'b1;
            state        <= READING;
          end else begin
            state <= MSG_WAIT;
          end
        end
        READING: begin
          if (app_rdy && app_req.addr == end_addr) begin
            app_req.en <= 1'b0;
            state      <= INTERFRAME;
          end else begin
            if (app_rdy) app_req.addr <= app_req.addr + `ADDR_WIDTH'(`ADDR_INC);
            if (coeff_high) begin
              app_req.en <= 1'b0;
              state      <= THROTTLED;
            end
          end
        end
        THROTTLED: begin
          if (!coeff_high) begin
            app_req.en <= 1'b1;
            state      <= READING;
          end
        end
        INTERFRAME: begin
          // next pass once the camera sits between frames
          if (frame_gap && !pix_empty) begin
            app_req.addr <= `ADDR_WIDTH'(`START_ADDR);
            app_req.en   <= 1'b1;
            state        <= READING;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // readback forwarding, one cycle behind the controller
  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      coeff_out <= '0;
    end else begin
      coeff_out.valid <= app_rd_data_valid;
      coeff_out.row   <= app_rd_data[`COEFF_ROW_LSB +: 4];
      coeff_out.data  <= app_rd_data;
    end
  end

  a_end_only_after_first_beat: assert property (
    @(posedge CLK) disable iff (fds_val) !app_wdf_end |-> app_wdf_wren && state == WR1);

  a_read_within_coeffs: assert property (
    @(posedge CLK) disable iff (fds_val) state == READING |-> app_req.addr <= end_addr);

endmodule

`default_nettype wire

// File: verilog/patch_front_end.sv
`timescale 1ns/1ps
`default_nettype none

`include "patch_front_end_defines.svh"

module patch_front_end (
  input  wire                        CLK,
  input  wire                        fds_val,
  input  wire                        pc_msg_pending,
  input  wire xb_msg_pkg::xb_msg_u   pc_msg,
  output logic                       pc_msg_ack,
  input  wire                        app_rdy,
  output dram_pkg::app_req_t         app_req,
  input  wire                        app_wdf_rdy,
  output logic                       app_wdf_wren,
  output logic                       app_wdf_end,
  output logic [`APP_DATA_WIDTH-1:0] app_wdf_data,
  input  wire                        app_rd_data_valid,
  input  wire [`APP_DATA_WIDTH-1:0]  app_rd_data,
  input  wire                        coeff_high,
  output xb_msg_pkg::pixel_beat_t    pixel_beat,
  output dram_pkg::coeff_rec_t       coeff_out,
  output logic                       error
);

  import xb_msg_pkg::*;

  xb_msg_u pix_msg;
  xb_msg_u dram_msg;
  logic    pix_rden;
  logic    pix_empty;
  logic    dram_rden;
  logic    dram_empty;
  logic    frame_gap;

  msg_router u_router (
    .CLK            (CLK),
    .fds_val        (fds_val),
    .pc_msg_pending (pc_msg_pending),
    .pc_msg         (pc_msg),
    .pc_msg_ack     (pc_msg_ack),
    .pix_rden       (pix_rden),
    .pix_msg        (pix_msg),
    .pix_empty      (pix_empty),
    .dram_rden      (dram_rden),
    .dram_msg       (dram_msg),
    .dram_empty     (dram_empty)
  );

  pixel_tracker u_tracker (
    .CLK       (CLK),
    .fds_val   (fds_val),
    .pix_msg   (pix_msg),
    .pix_empty (pix_empty),
    .pix_rden  (pix_rden),
    .beat      (pixel_beat),
    .frame_gap (frame_gap)
  );

  // frame_gap and pix_empty pace the per-frame readback
  dram_coeff_ifc u_dram_ifc (
    .CLK               (CLK),
    .fds_val           (fds_val),
    .dram_msg          (dram_msg),
    .dram_empty        (dram_empty),
    .dram_rden         (dram_rden),
    .frame_gap         (frame_gap),
    .pix_empty         (pix_empty),
    .app_rdy           (app_rdy),
    .app_req           (app_req),
    .app_wdf_rdy       (app_wdf_rdy),
    .app_wdf_wren      (app_wdf_wren),
    .app_wdf_end       (app_wdf_end),
    .app_wdf_data      (app_wdf_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data),
    .coeff_high        (coeff_high),
    .coeff_out         (coeff_out),
    .error             (error)
  );

endmodule

`default_nettype wire

// File: tb/tb_patch_front_end.sv
`timescale 1ns/1ps
`default_nettype none

`include "patch_front_end_defines.svh"

module tb_patch_front_end;

  import xb_msg_pkg::*;
  import dram_pkg::*;

  localparam int MAX_CYCLES = 4000;
  localparam int AW = `ADDR_WIDTH;
  localparam int DW = `APP_DATA_WIDTH;
  // reference tracker states
  localparam int R_STANDBY = 0;
  localparam int R_INTRALINE = 1;
  localparam int R_INTERLINE = 2;
  localparam int R_INTERFRAME = 3;

  logic           CLK;
  logic           fds_val;
  logic           pc_msg_pending;
  xb_msg_u        pc_msg;
  logic           pc_msg_ack;
  logic           app_rdy;
  app_req_t       app_req;
  logic           app_wdf_rdy;
  logic           app_wdf_wren;
  logic           app_wdf_end;
  logic [DW-1:0]  app_wdf_data;
  logic           app_rd_data_valid;
  logic [DW-1:0]  app_rd_data;
  logic           coeff_high;
  pixel_beat_t    pixel_beat;
  coeff_rec_t     coeff_out;
  logic           error;

  int seed = 70;
  int cycles = 0;
  int errors = 0;

  // expected write beats and pixel beats filled as stimulus is sent
  logic [DW-1:0]  exp_wdata [64];
  logic           exp_wend [64];
  pixel_beat_t    exp_beats [64];
  int             n_exp_pix = 0;
  int             n_exp_wr = 0;
  int             wr_beat_cnt = 0;
  int             wr_cmd_cnt = 0;
  int             pix_beat_cnt = 0;
  int             rd_cnt = 0;
  int             coeff_cnt = 0;
  int             pass_starts = 0;
  int             pass_ends = 0;
  logic [AW-1:0]  cur_wr_addr;
  logic [AW-1:0]  last_wr_addr;
  logic [AW-1:0]  exp_rd_addr;
  logic [DW-1:0]  dram_lo [16];
  logic           rd_pend;
  logic [AW-1:0]  rd_pend_addr;
  logic [DW-1:0]  rd_data_q;

  // reference position counters
  int                     ref_state = R_STANDBY;
  logic [`ROW_BITS-1:0]   ref_row = '0;
  logic [`COL_BITS-1:0]   ref_col = '0;
  logic [`FRAME_BITS-1:0] ref_frame = '0;

  logic           wr_cmd;
  logic           rd_acc;
  logic           wr_beat;
  logic [DW-1:0]  exp_wdata_cur;
  logic           exp_wend_cur;
  pixel_beat_t    exp_beat_cur;

  // a write command is taken together with room for its data
  assign wr_cmd        = app_req.en && app_rdy && app_wdf_rdy && !app_req.read;
  assign rd_acc        = app_req.en && app_rdy && app_req.read;
  assign wr_beat       = app_wdf_wren && app_wdf_rdy;
  assign exp_wdata_cur = exp_wdata[wr_beat_cnt];
  assign exp_wend_cur  = exp_wend[wr_beat_cnt];
  assign exp_beat_cur  = exp_beats[pix_beat_cnt];

  patch_front_end dut0 (
    .CLK               (CLK),
    .fds_val           (fds_val),
    .pc_msg_pending    (pc_msg_pending),
    .pc_msg            (pc_msg),
    .pc_msg_ack        (pc_msg_ack),
    .app_rdy           (app_rdy),
    .app_req           (app_req),
    .app_wdf_rdy       (app_wdf_rdy),
    .app_wdf_wren      (app_wdf_wren),
    .app_wdf_end       (app_wdf_end),
    .app_wdf_data      (app_wdf_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data),
    .coeff_high        (coeff_high),
    .pixel_beat        (pixel_beat),
    .coeff_out         (coeff_out),
    .error             (error)
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // DRAM model with random grants and read data two cycles after a granted read
  always @(posedge CLK) begin
    app_rdy     <= ($random(seed) & 3) != 0;
    // second beat must always be taken
    app_wdf_rdy <= app_wdf_wren || (($random(seed) & 3) != 0);
    if (wr_cmd) begin
      cur_wr_addr  <= app_req.addr;
      last_wr_addr <= app_req.addr;
      wr_cmd_cnt   <= wr_cmd_cnt + 1;
    end
    if (wr_beat) begin
      wr_beat_cnt <= wr_beat_cnt + 1;
      if (!app_wdf_end) dram_lo[cur_wr_addr[6:3]] <= app_wdf_data;
    end
    rd_pend      <= rd_acc;
    rd_pend_addr <= app_req.addr;
    app_rd_data_valid <= rd_pend;
    app_rd_data       <= dram_lo[rd_pend_addr[6:3]];
    rd_data_q         <= app_rd_data;
    if (rd_acc) begin
      rd_cnt <= rd_cnt + 1;
      if (exp_rd_addr == last_wr_addr) begin
        exp_rd_addr <= AW'(`START_ADDR);
        pass_ends   <= pass_ends + 1;
      end else begin
        exp_rd_addr <= exp_rd_addr + AW'(`ADDR_INC);
      end
      if (exp_rd_addr == AW'(`START_ADDR)) pass_starts <= pass_starts + 1;
    end
    if (pixel_beat.valid) pix_beat_cnt <= pix_beat_cnt + 1;
    if (coeff_out.valid) coeff_cnt <= coeff_cnt + 1;
  end

  a_reset_values: assert property (@(posedge CLK) $fell(fds_val) |->
      !app_req.en && !app_wdf_wren && app_wdf_end && !pixel_beat.valid &&
      !coeff_out.valid && !error)
    else begin
      errors++;
      $display("Error %0t {en,wren,end,beat,coeff,error} expected 001000 actual %b%b%b%b%b%b",
               $time, app_req.en, app_wdf_wren, app_wdf_end, pixel_beat.valid,
               coeff_out.valid, error);
    end

  a_wr_addr: assert property (@(posedge CLK) disable iff (fds_val)
      wr_cmd |-> app_req.addr == AW'(`START_ADDR + wr_cmd_cnt * `ADDR_INC))
    else begin
      errors++;
      $display("Error %0t app_req.addr expected %0h actual %0h", $time,
               `START_ADDR + wr_cmd_cnt * `ADDR_INC, app_req.addr);
    end

  a_wr_data: assert property (@(posedge CLK) disable iff (fds_val)
      wr_beat |-> app_wdf_data == exp_wdata_cur)
    else begin
      errors++;
      $display("Error %0t app_wdf_data expected %h actual %h", $time, exp_wdata_cur,
               app_wdf_data);
    end

  a_wr_end: assert property (@(posedge CLK) disable iff (fds_val)
      wr_beat |-> app_wdf_end == exp_wend_cur)
    else begin
      errors++;
      $display("Error %0t app_wdf_end expected %b actual %b", $time, exp_wend_cur,
               app_wdf_end);
    end

  a_rd_addr: assert property (@(posedge CLK) disable iff (fds_val)
      rd_acc |-> app_req.addr == exp_rd_addr)
    else begin
      errors++;
      $display("Error %0t app_req.addr expected %0h actual %0h", $time, exp_rd_addr,
               app_req.addr);
    end

  a_rd_stop: assert property (@(posedge CLK) disable iff (fds_val)
      rd_acc && exp_rd_addr == last_wr_addr |=> !app_req.en)
    else begin
      errors++;
      $display("Error %0t app_req.en expected 0 actual %b", $time, app_req.en);
    end

  a_throttle: assert property (@(posedge CLK) disable iff (fds_val)
      coeff_high && $past(coeff_high) |-> !app_req.en)
    else begin
      errors++;
      $display("Error %0t app_req.en expected 0 actual %b", $time, app_req.en);
    end

  a_coeff_valid: assert property (@(posedge CLK) disable iff (fds_val)
      app_rd_data_valid |=> coeff_out.valid)
    else begin
      errors++;
      $display("Error %0t coeff_out.valid expected 1 actual %b", $time, coeff_out.valid);
    end

  a_coeff_data: assert property (@(posedge CLK) disable iff (fds_val)
      app_rd_data_valid |=> coeff_out.data == rd_data_q)
    else begin
      errors++;
      $display("Error %0t coeff_out.data expected %h actual %h", $time, rd_data_q,
               coeff_out.data);
    end

  a_coeff_row: assert property (@(posedge CLK) disable iff (fds_val)
      app_rd_data_valid |=> coeff_out.row == rd_data_q[7:4])
    else begin
      errors++;
      $display("Error %0t coeff_out.row expected %h actual %h", $time, rd_data_q[7:4],
               coeff_out.row);
    end

  a_pixel_beat: assert property (@(posedge CLK) disable iff (fds_val)
      pixel_beat.valid |-> pixel_beat == exp_beat_cur)
    else begin
      errors++;
      $display("Error %0t pixel_beat expected %h actual %h", $time, exp_beat_cur,
               pixel_beat);
    end

  a_no_error: assert property (@(posedge CLK) disable iff (fds_val) !error)
    else begin
      errors++;
      $display("Error %0t error expected 0 actual %b", $time, error);
    end

  task automatic transfer_msg(input logic [`XB_WIDTH-1:0] w);
    int gap;
    gap = $random(seed) & 1;
    repeat (gap) @(posedge CLK);
    @(posedge CLK);
    pc_msg_pending <= 1'b1;
    pc_msg         <= w;
    do @(posedge CLK); while (!pc_msg_ack);
    pc_msg_pending <= 1'b0;
  endtask

  // four words with a nonzero first tag and word 2 low bits picking end or not
  task automatic queue_burst(input logic is_end);
    logic [`XB_WIDTH-1:0] w [4];
    foreach (w[i]) w[i] = $random(seed);
    w[0][1:0] = 2'b10;
    w[2][1:0] = is_end ? `COEFF_END_TAG : 2'b11;
    exp_wdata[n_exp_wr]     = {w[1], w[0]};
    exp_wend[n_exp_wr]      = 1'b0;
    exp_wdata[n_exp_wr + 1] = {w[3], w[2]};
    exp_wend[n_exp_wr + 1]  = 1'b1;
    n_exp_wr = n_exp_wr + 2;
    foreach (w[i]) transfer_msg(w[i]);
  endtask

  task automatic emit_pixel_pair(input logic fv, input logic lv);
    logic [`FP_SIZE-1:0] p1;
    logic [`FP_SIZE-1:0] p0;
    p1 = `FP_SIZE'($random(seed));
    p0 = `FP_SIZE'($random(seed));
    exp_beats[n_exp_pix] = '{valid: 1'b1, fval: fv, lval: lv, row: ref_row, col: ref_col,
                             frame: ref_frame, pix0: p0, pix1: p1};
    n_exp_pix++;
    case (ref_state)
      R_STANDBY: begin
        if (!fv) begin
          ref_row = '0;
          ref_col = '0;
          ref_frame = '0;
          ref_state = R_INTERFRAME;
        end
      end
      R_INTERFRAME: begin
        if (lv) begin
          ref_row = '0;
          ref_col = '0;
          ref_state = R_INTRALINE;
        end
      end
      R_INTRALINE: begin
        if (lv) begin
          ref_col = ref_col + 2;
        end else if (fv) begin
          ref_row = ref_row + 1;
          ref_state = R_INTERLINE;
        end else begin
          ref_frame = ref_frame + 1;
          ref_state = R_INTERFRAME;
        end
      end
      default: begin
        if (lv) begin
          ref_col = '0;
          ref_state = R_INTRALINE;
        end
      end
    endcase
    transfer_msg({p1, 8'h00, fv, lv, `DS_TAG});
    transfer_msg({p0, 8'h00, fv, lv, `DS_TAG});
  endtask

  // gap pair then two lines of three pairs and the frame end
  task automatic play_frame();
    emit_pixel_pair(1'b0, 1'b0);
    for (int ln = 0; ln < 2; ln++) begin
      repeat (3) emit_pixel_pair(1'b1, 1'b1);
      if (ln == 0) emit_pixel_pair(1'b1, 1'b0);
    end
    emit_pixel_pair(1'b0, 1'b0);
  endtask

  initial begin
    CLK = 1'b0;
    fds_val = 1'b1;
    pc_msg_pending = 1'b0;
    pc_msg = '0;
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data = '0;
    coeff_high = 1'b0;
    rd_pend = 1'b0;
    rd_pend_addr = '0;
    cur_wr_addr = '0;
    last_wr_addr = '0;
    exp_rd_addr = AW'(`START_ADDR);
    repeat (5) @(posedge CLK);
    fds_val <= 1'b0;
    repeat (2) @(posedge CLK);
    $display("test 1 reset values done, errors %0d", errors);

    for (int k = 0; k < 3; k++) begin
      emit_pixel_pair(1'b0, 1'b0);
      queue_burst(1'b0);
    end
    while (wr_beat_cnt < 6) @(posedge CLK);
    $display("test 2 coefficient bursts done, errors %0d", errors);

    queue_burst(1'b1);
    while (!rd_acc) @(posedge CLK);
    $display("test 3 end marker and readback start done, errors %0d", errors);

    coeff_high <= 1'b1;
    repeat (6) @(posedge CLK);
    coeff_high <= 1'b0;
    while (pass_ends < 1) @(posedge CLK);
    $display("test 4 throttled readback done, errors %0d", errors);

    while (coeff_cnt != rd_cnt) @(posedge CLK);
    $display("test 5 coefficient records done, errors %0d", errors);

    repeat (2) play_frame();
    while (pix_beat_cnt < n_exp_pix || pass_starts < 2 || pass_ends != pass_starts ||
           coeff_cnt != rd_cnt) @(posedge CLK);
    $display("test 6 pixel beats and per-frame readback done, errors %0d", errors);

    $display("totals: write beats %0d, reads %0d, pixel beats %0d, coeff words %0d, errors %0d",
             wr_beat_cnt, rd_cnt, pix_beat_cnt, coeff_cnt, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: patch_front_end.f
+incdir+verilog
verilog/xb_msg_pkg.sv
verilog/dram_pkg.sv
verilog/msg_fifo.sv
verilog/msg_router.sv
verilog/pixel_tracker.sv
verilog/dram_coeff_ifc.sv
verilog/patch_front_end.sv
tb/tb_patch_front_end.sv

// File: Makefile
TOP := tb_patch_front_end

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f patch_front_end.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f patch_front_end.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "failure reported, see sim.log"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
